// File: common/core_pkg.sv
package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [63:0] xlen_t;      // data word or byte address.
    typedef logic [31:0] inst_t;      // one instruction word.
    typedef logic [4:0]  reg_addr_t;  // register index.
    typedef logic [3:0]  alu_sel_t;   // alu operation selector.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam alu_sel_t ALU_ADD    = 4'd0;
    localparam alu_sel_t ALU_SUB    = 4'd1;
    localparam alu_sel_t ALU_AND    = 4'd2;
    localparam alu_sel_t ALU_OR     = 4'd3;
    localparam alu_sel_t ALU_XOR    = 4'd4;
    localparam alu_sel_t ALU_SLL    = 4'd5;
    localparam alu_sel_t ALU_SRL    = 4'd6;
    localparam alu_sel_t ALU_SRA    = 4'd7;
    localparam alu_sel_t ALU_SLT    = 4'd8;
    localparam alu_sel_t ALU_SLTU   = 4'd9;
    localparam alu_sel_t ALU_PASS_B = 4'd10;  // result is op2, used by lui.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_DOUBLE  = 3'b011;  // ld and sd width code.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        xlen_t     op1;
        xlen_t     op2;
        alu_sel_t  alu_sel;
        logic      reg_we;
        reg_addr_t reg_waddr;
        logic      ram_re;
        logic      ram_we;
        xlen_t     ram_wdata;
        logic      illegal;
    } ex_ctrl_t;

    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        logic      rd_we;
        reg_addr_t rd;
        xlen_t     rd_data;
        logic      mem_we;
        xlen_t     mem_addr;
        xlen_t     mem_wdata;
        logic      illegal;
    } retire_t;

endpackage

// File: decode/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import core_pkg::*; (
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    input  logic      fwd_valid_i,
    input  reg_addr_t fwd_rd_i,
    input  xlen_t     fwd_data_i,
    input  logic      dec_ready_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      inst_ready_o,
    output logic      dec_valid_o,
    output ex_ctrl_t  dec_ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    logic       legal;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'h000};

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // the instruction sitting in execute has not written back yet.
    assign rs1_val = (fwd_valid_i && fwd_rd_i != '0 && fwd_rd_i == rs1) ? fwd_data_i : rs1_data_i;
    assign rs2_val = (fwd_valid_i && fwd_rd_i != '0 && fwd_rd_i == rs2) ? fwd_data_i : rs2_data_i;

    assign dec_valid_o  = inst_valid_i;
    assign inst_ready_o = dec_ready_i;

    always_comb begin
        dec_ctrl_o           = '0;
        dec_ctrl_o.pc        = pc_i;
        dec_ctrl_o.inst      = inst_i;
        dec_ctrl_o.op1       = rs1_val;
        dec_ctrl_o.op2       = rs2_val;
        dec_ctrl_o.alu_sel   = ALU_ADD;
        dec_ctrl_o.reg_waddr = rd;
        dec_ctrl_o.ram_wdata = rs2_val;
        legal                = 1'b1;
        case (opcode)
            OPC_OP: begin
                dec_ctrl_o.reg_we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec_ctrl_o.alu_sel = ALU_ADD;
                    10'b0100000_000: dec_ctrl_o.alu_sel = ALU_SUB;
                    10'b0000000_001: dec_ctrl_o.alu_sel = ALU_SLL;
                    10'b0000000_010: dec_ctrl_o.alu_sel = ALU_SLT;
                    10'b0000000_011: dec_ctrl_o.alu_sel = ALU_SLTU;
                    10'b0000000_100: dec_ctrl_o.alu_sel = ALU_XOR;
                    10'b0000000_101: dec_ctrl_o.alu_sel = ALU_SRL;
                    10'b0100000_101: dec_ctrl_o.alu_sel = ALU_SRA;
                    10'b0000000_110: dec_ctrl_o.alu_sel = ALU_OR;
                    10'b0000000_111: dec_ctrl_o.alu_sel = ALU_AND;
                    default:         legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec_ctrl_o.reg_we = 1'b1;
                dec_ctrl_o.op2    = imm_i;
                case (funct3)
                    3'b000:  dec_ctrl_o.alu_sel = ALU_ADD;
                    3'b010:  dec_ctrl_o.alu_sel = ALU_SLT;
                    3'b100:  dec_ctrl_o.alu_sel = ALU_XOR;
                    3'b110:  dec_ctrl_o.alu_sel = ALU_OR;
                    3'b111:  dec_ctrl_o.alu_sel = ALU_AND;
                    default: legal = 1'b0;  // immediate shifts are not supported.
                endcase
            end
            OPC_LUI: begin
                dec_ctrl_o.reg_we  = 1'b1;
                dec_ctrl_o.op1     = '0;
                dec_ctrl_o.op2     = imm_u;
                dec_ctrl_o.alu_sel = ALU_PASS_B;
            end
            OPC_LOAD: begin
                dec_ctrl_o.reg_we = 1'b1;
                dec_ctrl_o.ram_re = 1'b1;
                dec_ctrl_o.op2    = imm_i;  // alu adds base and offset.
                legal             = (funct3 == F3_DOUBLE);
            end
            OPC_STORE: begin
                dec_ctrl_o.ram_we = 1'b1;
                dec_ctrl_o.op2    = imm_s;
                legal             = (funct3 == F3_DOUBLE);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            dec_ctrl_o.reg_we  = 1'b0;  // no side effects for unknown encodings.
            dec_ctrl_o.ram_re  = 1'b0;
            dec_ctrl_o.ram_we  = 1'b0;
            dec_ctrl_o.illegal = 1'b1;
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    input  logic      wb_we_i,
    input  reg_addr_t wb_addr_i,
    input  xlen_t     wb_data_i
);

    xlen_t regs [1:31];  // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // reads are combinational, so a write shows up in the next cycle.
    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

// File: logic/id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid_i,
    input  ex_ctrl_t in_ctrl_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output ex_ctrl_t out_ctrl_o,
    input  logic     out_ready_i
);

    // the slot can take a new bundle when it is empty or is being drained.
    assign in_ready_o = !out_valid_o || out_ready_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst_n) begin
            out_valid_o          <= 1'b0;
            out_ctrl_o.alu_sel   <= ALU_ADD;
            out_ctrl_o.reg_we    <= 1'b0;
            out_ctrl_o.reg_waddr <= '0;
            out_ctrl_o.ram_re    <= 1'b0;
            out_ctrl_o.ram_we    <= 1'b0;
            out_ctrl_o.illegal   <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;  // drops when drained with no input.
            out_ctrl_o  <= in_ctrl_i;
        end
    end

endmodule

// File: execute/alu_unit.sv
`timescale 1ns/100ps

module alu_unit import core_pkg::*; (
    input  logic      ex_valid_i,
    input  ex_ctrl_t  ex_ctrl_i,
    input  logic      retire_ready_i,
    input  xlen_t     ram_rdata_i,
    output logic      retire_valid_o,
    output retire_t   retire_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output xlen_t     wb_data_o,
    output logic      mem_we_o,
    output xlen_t     mem_addr_o,
    output xlen_t     mem_wdata_o,
    output logic      fwd_valid_o,
    output reg_addr_t fwd_rd_o,
    output xlen_t     fwd_data_o
);

    xlen_t      op1;
    xlen_t      op2;
    xlen_t      alu_res;
    xlen_t      result;
    logic [5:0] shamt;
    logic       fire;

    assign op1   = ex_ctrl_i.op1;
    assign op2   = ex_ctrl_i.op2;
    assign shamt = op2[5:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (ex_ctrl_i.alu_sel)
            ALU_ADD:    alu_res = op1 + op2;
            ALU_SUB:    alu_res = op1 - op2;
            ALU_AND:    alu_res = op1 & op2;
            ALU_OR:     alu_res = op1 | op2;
            ALU_XOR:    alu_res = op1 ^ op2;
            ALU_SLL:    alu_res = op1 << shamt;
            ALU_SRL:    alu_res = op1 >> shamt;
            ALU_SRA:    alu_res = xlen_t'($signed(op1) >>> shamt);
            ALU_SLT:    alu_res = {63'd0, $signed(op1) < $signed(op2)};
            ALU_SLTU:   alu_res = {63'd0, op1 < op2};
            ALU_PASS_B: alu_res = op2;
            default:    alu_res = '0;
        endcase
    end

    assign result = ex_ctrl_i.ram_re ? ram_rdata_i : alu_res;  // loads take memory data.
    assign fire   = ex_valid_i && retire_ready_i;

    // side effects happen only on the retire handshake.
    assign wb_we_o     = fire && ex_ctrl_i.reg_we;
    assign wb_addr_o   = ex_ctrl_i.reg_waddr;
    assign wb_data_o   = result;
    assign mem_we_o    = fire && ex_ctrl_i.ram_we;
    assign mem_addr_o  = alu_res;
    assign mem_wdata_o = ex_ctrl_i.ram_wdata;

    assign fwd_valid_o = ex_valid_i && ex_ctrl_i.reg_we;
    assign fwd_rd_o    = ex_ctrl_i.reg_waddr;
    assign fwd_data_o  = result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retire record
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign retire_valid_o = ex_valid_i;

    always_comb begin
        retire_o.pc        = ex_ctrl_i.pc;
        retire_o.inst      = ex_ctrl_i.inst;
        retire_o.rd_we     = ex_ctrl_i.reg_we;
        retire_o.rd        = ex_ctrl_i.reg_waddr;
        retire_o.rd_data   = ex_ctrl_i.reg_we ? result : '0;
        retire_o.mem_we    = ex_ctrl_i.ram_we;
        retire_o.mem_addr  = (ex_ctrl_i.ram_we || ex_ctrl_i.ram_re) ? alu_res : '0;
        retire_o.mem_wdata = ex_ctrl_i.ram_we ? ex_ctrl_i.ram_wdata : '0;
        retire_o.illegal   = ex_ctrl_i.illegal;
    end

endmodule

// File: logic/data_ram.sv
`timescale 1ns/100ps

module data_ram import core_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic  clk,
    input  logic  rst_n,
    input  xlen_t addr_i,
    input  logic  we_i,
    input  xlen_t wdata_i,
    output xlen_t rdata_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    xlen_t         mem [DMEM_WORDS];
    logic [AW-1:0] idx;

    // the upper address bits are dropped so addresses wrap around.
    assign idx = addr_i[AW+2:3];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[idx];  // combinational read.

endmodule

// File: logic/exec_core_top.sv
`timescale 1ns/100ps

module exec_core_top import core_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    inst_valid_i,
    input  inst_t   inst_i,
    input  xlen_t   pc_i,
    output logic    inst_ready_o,
    output logic    retire_valid_o,
    output retire_t retire_o,
    input  logic    retire_ready_i
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      dec_valid;
    logic      dec_ready;
    ex_ctrl_t  dec_ctrl;
    logic      ex_valid;
    ex_ctrl_t  ex_ctrl;
    logic      wb_we;
    reg_addr_t wb_addr;
    xlen_t     wb_data;
    logic      mem_we;
    xlen_t     mem_addr;
    xlen_t     mem_wdata;
    xlen_t     ram_rdata;
    logic      fwd_valid;
    reg_addr_t fwd_rd;
    xlen_t     fwd_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    inst_decoder u_decoder (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fwd_valid_i  (fwd_valid),
        .fwd_rd_i     (fwd_rd),
        .fwd_data_i   (fwd_data),
        .dec_ready_i  (dec_ready),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .inst_ready_o (inst_ready_o),
        .dec_valid_o  (dec_valid),
        .dec_ctrl_o   (dec_ctrl)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_we_i    (wb_we),
        .wb_addr_i  (wb_addr),
        .wb_data_i  (wb_data)
    );

    id_ex_reg u_id_ex (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (dec_valid),
        .in_ctrl_i   (dec_ctrl),
        .in_ready_o  (dec_ready),
        .out_valid_o (ex_valid),
        .out_ctrl_o  (ex_ctrl),
        .out_ready_i (retire_ready_i)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute and memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    alu_unit u_alu (
        .ex_valid_i     (ex_valid),
        .ex_ctrl_i      (ex_ctrl),
        .retire_ready_i (retire_ready_i),
        .ram_rdata_i    (ram_rdata),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .wb_we_o        (wb_we),
        .wb_addr_o      (wb_addr),
        .wb_data_o      (wb_data),
        .mem_we_o       (mem_we),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata),
        .fwd_valid_o    (fwd_valid),
        .fwd_rd_o       (fwd_rd),
        .fwd_data_o     (fwd_data)
    );

    data_ram #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr_i  (mem_addr),
        .we_i    (mem_we),
        .wdata_i (mem_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

// File: tests/tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core import core_pkg::*; ();

    localparam int MEM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = 200;

    logic    clk;
    logic    rst_n;
    logic    inst_valid_i;
    inst_t   inst_i;
    xlen_t   pc_i;
    logic    inst_ready_o;
    logic    retire_valid_o;
    retire_t retire_o;
    logic    retire_ready_i;

    xlen_t   model_regs [32];
    xlen_t   model_mem [MEM_WORDS];
    retire_t expect_q [$];
    string   test_name;
    xlen_t   next_pc;
    int      accept_count;
    int      retire_count;
    logic    random_ready;
    logic    no_stall;

    exec_core_top #(
        .DMEM_WORDS (MEM_WORDS)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .inst_ready_o   (inst_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period.

    always @(negedge clk) begin
        if (random_ready) begin
            retire_ready_i = ($urandom_range(0, 2) != 0);
        end else begin
            retire_ready_i = 1'b1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(input logic [2:0] f3, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic inst_t enc_u(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic reg_addr_t rand_reg();
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic inst_t rand_alu(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
        logic [11:0] imm;
        inst_t       w;
        imm = 12'($urandom);
        case (int'($urandom_range(0, 15)))
            0:       w = enc_r(7'h00, 3'b000, rd, rs1, rs2);
            1:       w = enc_r(7'h20, 3'b000, rd, rs1, rs2);
            2:       w = enc_r(7'h00, 3'b111, rd, rs1, rs2);
            3:       w = enc_r(7'h00, 3'b110, rd, rs1, rs2);
            4:       w = enc_r(7'h00, 3'b100, rd, rs1, rs2);
            5:       w = enc_r(7'h00, 3'b001, rd, rs1, rs2);
            6:       w = enc_r(7'h00, 3'b101, rd, rs1, rs2);
            7:       w = enc_r(7'h20, 3'b101, rd, rs1, rs2);
            8:       w = enc_r(7'h00, 3'b010, rd, rs1, rs2);
            9:       w = enc_r(7'h00, 3'b011, rd, rs1, rs2);
            10:      w = enc_i(7'b0010011, 3'b000, rd, rs1, imm);
            11:      w = enc_i(7'b0010011, 3'b111, rd, rs1, imm);
            12:      w = enc_i(7'b0010011, 3'b110, rd, rs1, imm);
            13:      w = enc_i(7'b0010011, 3'b100, rd, rs1, imm);
            14:      w = enc_i(7'b0010011, 3'b010, rd, rs1, imm);
            default: w = enc_u(rd, 20'($urandom));
        endcase
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_step(input inst_t inst, input xlen_t pc, output retire_t r);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  rd;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      imm_s;
        xlen_t      val;
        xlen_t      addr;
        logic       legal;
        logic       writes;
        opc    = inst[6:0];
        rd     = inst[11:7];
        f3     = inst[14:12];
        f7     = inst[31:25];
        a      = model_regs[inst[19:15]];
        b      = model_regs[inst[24:20]];
        imm_i  = {{52{inst[31]}}, inst[31:20]};
        imm_s  = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        r      = '0;
        r.pc   = pc;
        r.inst = inst;
        r.rd   = rd;
        legal  = 1'b1;
        writes = 1'b1;
        val    = '0;
        case (opc)
            7'b0110011: begin
                case ({f7, f3})
                    10'h000: val = a + b;
                    10'h100: val = a - b;
                    10'h007: val = a & b;
                    10'h006: val = a | b;
                    10'h004: val = a ^ b;
                    10'h001: val = a << b[5:0];
                    10'h005: val = a >> b[5:0];
                    10'h105: val = xlen_t'($signed(a) >>> b[5:0]);
                    10'h002: val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    10'h003: val = (a < b) ? 64'd1 : 64'd0;
                    default: legal = 1'b0;
                endcase
            end
            7'b0010011: begin
                case (f3)
                    3'b000:  val = a + imm_i;
                    3'b111:  val = a & imm_i;
                    3'b110:  val = a | imm_i;
                    3'b100:  val = a ^ imm_i;
                    3'b010:  val = ($signed(a) < $signed(imm_i)) ? 64'd1 : 64'd0;
                    default: legal = 1'b0;
                endcase
            end
            7'b0110111: val = {{32{inst[31]}}, inst[31:12], 12'h000};
            7'b0000011: begin
                legal = (f3 == 3'b011);
                addr  = a + imm_i;
                if (legal) begin
                    val        = model_mem[addr[8:3]];  // 64 doublewords wrap.
                    r.mem_addr = addr;
                end
            end
            7'b0100011: begin
                legal  = (f3 == 3'b011);
                writes = 1'b0;
                addr   = a + imm_s;
                if (legal) begin
                    r.mem_we             = 1'b1;
                    r.mem_addr           = addr;
                    r.mem_wdata          = b;
                    model_mem[addr[8:3]] = b;
                end
            end
            default: legal = 1'b0;
        endcase
        r.illegal = !legal;
        if (legal && writes) begin
            r.rd_we   = 1'b1;
            r.rd_data = val;
            if (rd != 5'd0) begin
                model_regs[rd] = val;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        retire_t exp;
        if (!rst_n && retire_valid_o && retire_ready_i) begin
            if (expect_q.size() == 0) begin
                abort_run("an instruction retired that was never accepted");
            end else begin
                exp = expect_q.pop_front();
                retire_count++;
                assert (retire_o == exp) else abort_run($sformatf(
                    "Mismatch in %s: expected %h, actual %h", test_name, exp, retire_o));
            end
        end
        if (!rst_n && inst_valid_i && inst_ready_o) begin
            model_step(inst_i, pc_i, exp);
            expect_q.push_back(exp);
            accept_count++;
        end
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (rst_n)
        (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && retire_o == $past(retire_o)))
        else abort_run("retire_o changed while retire_ready_i was low");

    no_accept_while_full: assert property (@(posedge clk) disable iff (rst_n)
        (retire_valid_o && !retire_ready_i) |-> !inst_ready_o)
        else abort_run("inst_ready_o was high while the ID/EX slot was full and stalled");

    accept_when_free: assert property (@(posedge clk) disable iff (rst_n)
        (!retire_valid_o || retire_ready_i) |-> inst_ready_o)
        else abort_run("inst_ready_o was low while the ID/EX slot was empty or draining");

    task automatic check_idle(input string when);
        assert (!retire_valid_o && inst_ready_o) else abort_run($sformatf(
            "retire_valid_o high or inst_ready_o low %s", when));
    endtask

    // returns at the falling edge after the accepting edge.
    task automatic issue(input inst_t inst);
        int start;
        int waited;
        start        = accept_count;
        waited       = 0;
        inst_valid_i = 1'b1;
        inst_i       = inst;
        pc_i         = next_pc;
        while (accept_count == start) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("an instruction was never accepted");
            end
        end
        if (no_stall && waited != 1) begin
            abort_run("back-to-back issue stalled while retire_ready_i was high");
        end
        next_pc = next_pc + 64'd4;
    endtask

    task automatic drain();
        int waited;
        inst_valid_i = 1'b0;
        waited       = 0;
        while (expect_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("accepted instructions did not retire");
            end
        end
    endtask

    initial begin
        reg_addr_t prev_rd;
        reg_addr_t dst;
        void'($urandom(32'h50d5));
        rst_n          = 1'b1;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        pc_i           = '0;
        retire_ready_i = 1'b1;
        random_ready   = 1'b0;
        no_stall       = 1'b0;
        next_pc        = 64'h1000;
        accept_count   = 0;
        retire_count   = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end

        test_name = "reset";
        repeat (8) begin
            @(negedge clk);
            check_idle("during reset");
        end
        rst_n = 1'b0;
        @(negedge clk);
        check_idle("after reset");

        test_name = "first_retire";
        no_stall  = 1'b1;
        issue(enc_i(7'b0010011, 3'b000, 5'd1, 5'd0, 12'h123));
        inst_valid_i = 1'b0;
        no_stall     = 1'b0;
        assert (retire_valid_o) else abort_run("first instruction did not reach retire_o");
        @(negedge clk);
        assert (retire_count == 1) else abort_run("first instruction did not retire in time");

        test_name = "random_alu";
        for (int i = 1; i < 32; i++) begin
            issue(enc_u(5'(i), 20'($urandom)));
            issue(enc_i(7'b0010011, 3'b000, 5'(i), 5'(i), 12'($urandom)));
        end
        repeat (200) issue(rand_alu(rand_reg(), rand_reg(), rand_reg()));
        drain();

        test_name = "dependent_chain";
        no_stall  = 1'b1;
        prev_rd   = 5'd1;
        repeat (60) begin
            dst = 5'($urandom_range(1, 31));
            issue(rand_alu(dst, prev_rd, ($urandom_range(0, 1) != 0) ? prev_rd : rand_reg()));
            prev_rd = dst;
        end
        drain();
        no_stall = 1'b0;

        test_name    = "back_pressure";
        random_ready = 1'b1;
        repeat (250) begin
            case (int'($urandom_range(0, 3)))
                0:       issue(enc_s(3'b011, rand_reg(), rand_reg(), 12'($urandom)));
                1:       issue(enc_i(7'b0000011, 3'b011, rand_reg(), rand_reg(), 12'($urandom)));
                default: issue(rand_alu(rand_reg(), rand_reg(), rand_reg()));
            endcase
        end
        drain();
        random_ready = 1'b0;

        test_name = "memory";
        issue(enc_i(7'b0010011, 3'b000, 5'd5, 5'd0, 12'h040));
        issue(enc_u(5'd6, 20'($urandom)));
        issue(enc_i(7'b0010011, 3'b100, 5'd6, 5'd6, 12'($urandom)));
        issue(enc_s(3'b011, 5'd5, 5'd6, 12'h008));
        issue(enc_i(7'b0000011, 3'b011, 5'd7, 5'd5, 12'h008));
        issue(enc_i(7'b0010011, 3'b000, 5'd8, 5'd0, 12'h248));  // aliases 0x048.
        issue(enc_i(7'b0000011, 3'b011, 5'd9, 5'd8, 12'h000));
        issue(enc_s(3'b011, 5'd8, 5'd1, 12'h000));
        issue(enc_i(7'b0000011, 3'b011, 5'd10, 5'd5, 12'h008));
        drain();

        test_name = "illegal_and_x0";
        issue(32'hffff_ffff);
        issue(enc_i(7'b0010011, 3'b001, 5'd3, 5'd4, 12'h005));
        issue(enc_i(7'b0000011, 3'b010, 5'd3, 5'd5, 12'h008));
        issue(enc_s(3'b010, 5'd5, 5'd2, 12'h008));
        issue(enc_r(7'h01, 3'b000, 5'd3, 5'd4, 5'd2));
        issue(enc_i(7'b0010011, 3'b000, 5'd0, 5'd1, 12'h07b));
        issue(enc_r(7'h00, 3'b000, 5'd11, 5'd0, 5'd0));
        issue(enc_i(7'b0000011, 3'b011, 5'd12, 5'd5, 12'h008));
        for (int i = 1; i < 32; i++) begin
            issue(enc_r(7'h00, 3'b000, 5'(i), 5'(i), 5'd0));  // reads back every register.
        end
        drain();

        if (!retire_valid_o) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("retire_valid_o stayed high after every accepted instruction retired");
        end
    end

endmodule

// File: verilog.f
common/core_pkg.sv
decode/inst_decoder.sv
logic/reg_file.sv
logic/id_ex_reg.sv
execute/alu_unit.sv
logic/data_ram.sv
logic/exec_core_top.sv
tests/tb_exec_core.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status is the verdict.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_exec_core -f verilog.f &&
./obj_dir/Vtb_exec_core || exit 1
